//--- Makefile
TOP := tb_banked_sram
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Result: PASSED" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- bench/banked_sram_asserts.sv
`timescale 1ns/1ns

module banked_sram_asserts (
  input logic                                clk,
  input logic                                rst,
  input logic [mem_cfg_pkg::NUM_BANKS-1:0]   bank_en,    // enables as the banks see them
  input logic                                rd_en,      // read strobe into the return mux
  input logic [mem_cfg_pkg::DATA_WIDTH-1:0]  rdata
);

  // at most one bank per request
  a_bank_en_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(bank_en))
    else $error("one request enables more than one bank");

  a_rdata_reset: assert property (@(posedge clk) rst |=> rdata == '0)
    else $error("rdata not cleared by reset");

  // an idle cycle leaves rdata alone two edges on
  a_rdata_hold: assert property (@(posedge clk) disable iff (rst) !rd_en |=> ##1 $stable(rdata))
    else $error("rdata changed without a read");

endmodule

bind banked_sram_top banked_sram_asserts i_port_a_chk (
  .clk     (clk),
  .rst     (rst),
  .bank_en ({bank_rw[7].en, bank_rw[6].en, bank_rw[5].en, bank_rw[4].en,
             bank_rw[3].en, bank_rw[2].en, bank_rw[1].en, bank_rw[0].en}),
  .rd_en   (u_ret_a.rd_en),
  .rdata   (rdata_a)
);

bind banked_sram_top banked_sram_asserts i_port_b_chk (
  .clk     (clk),
  .rst     (rst),
  .bank_en ({bank_rd[7].en, bank_rd[6].en, bank_rd[5].en, bank_rd[4].en,
             bank_rd[3].en, bank_rd[2].en, bank_rd[1].en, bank_rd[0].en}),
  .rd_en   (u_ret_b.rd_en),
  .rdata   (rdata_b)
);

//--- bench/tb_banked_sram.sv
`timescale 1ns/1ns

module tb_banked_sram;

  import mem_cfg_pkg::*;
  import mem_port_pkg::*;

  localparam int MAX_CYCLES = 8000;                      // about 6560 cycles of traffic, with headroom

  logic                  clk = 1'b0;
  logic                  rst;
  rw_req_t               port_a;
  rd_req_t               port_b;
  logic [DATA_WIDTH-1:0] rdata_a;
  logic [DATA_WIDTH-1:0] rdata_b;

  logic [DATA_WIDTH-1:0] shadow [MEM_DEPTH];             // reference copy of the memory
  logic [DATA_WIDTH-1:0] pipe_a;                         // word in flight, port A
  logic [DATA_WIDTH-1:0] pipe_b;
  logic                  pipe_a_vld;
  logic                  pipe_b_vld;
  logic [DATA_WIDTH-1:0] exp_a;                          // expected rdata_a, held between reads
  logic [DATA_WIDTH-1:0] exp_b;
  logic [31:0]           rng;
  int                    cycle_count = 0;

  banked_sram_top i_dut (
    .clk     (clk),
    .rst     (rst),
    .port_a  (port_a),
    .port_b  (port_b),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // each set mask bit replaces one byte of the old word
  function automatic logic [DATA_WIDTH-1:0] merge_write(input logic [DATA_WIDTH-1:0] old,
                                                        input logic [DATA_WIDTH-1:0] wdata,
                                                        input logic [NUM_WMASKS-1:0] wmask);
    logic [DATA_WIDTH-1:0] word;
    word = old;
    for (int lane = 0; lane < NUM_WMASKS; lane++) begin
      if (wmask[lane]) begin
        word[lane*8 +: 8] = wdata[lane*8 +: 8];
      end
    end
    return word;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] expected_read(input logic [ADDR_WIDTH-1:0] addr);
    return shadow[addr];
  endfunction

  function automatic rw_req_t write_req(input logic [ADDR_WIDTH-1:0] addr,
                                        input logic [NUM_WMASKS-1:0] wmask,
                                        input logic [DATA_WIDTH-1:0] wdata);
    rw_req_t r;
    r = '0;
    r.en = 1'b1;
    r.we = 1'b1;
    r.wmask = wmask;
    r.addr.flat = addr;
    r.wdata = wdata;
    return r;
  endfunction

  function automatic rw_req_t read_req(input logic [ADDR_WIDTH-1:0] addr);
    rw_req_t r;
    r = '0;
    r.en = 1'b1;
    r.addr.flat = addr;
    return r;
  endfunction

  function automatic rd_req_t b_read_req(input logic [ADDR_WIDTH-1:0] addr);
    rd_req_t r;
    r.en = 1'b1;
    r.addr.flat = addr;
    return r;
  endfunction

  task automatic drive(input rw_req_t a, input rd_req_t b);
    @(posedge clk);
    port_a <= a;
    port_b <= b;
  endtask

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] actual,
                             input logic [DATA_WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s = %08h, expected %08h", $time, name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "read data mismatch");
    end
  endtask

  // model follows the request the DUT samples at this edge, reads before writes
  always @(posedge clk) begin
    if (rst) begin
      pipe_a_vld = 1'b0;
      pipe_b_vld = 1'b0;
      exp_a = '0;
      exp_b = '0;
    end else begin
      if (pipe_a_vld) exp_a = pipe_a;
      if (pipe_b_vld) exp_b = pipe_b;
      pipe_a_vld = port_a.en && !port_a.we;
      pipe_a = expected_read(port_a.addr.flat);
      pipe_b_vld = port_b.en;
      pipe_b = expected_read(port_b.addr.flat);
      if (port_a.en && port_a.we) begin
        shadow[port_a.addr.flat] = merge_write(shadow[port_a.addr.flat], port_a.wdata,
                                               port_a.wmask);
      end
    end
  end

  always @(negedge clk) begin                            // outputs settled mid-cycle
    if (!rst) begin
      check_value("rdata_a", rdata_a, exp_a);
      check_value("rdata_b", rdata_b, exp_b);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [ADDR_WIDTH-1:0] addr;
    logic [31:0]           ctl;
    rw_req_t               a_req;
    rd_req_t               b_req;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      shadow[i] = '0;                                    // banks come up cleared
    end
    rng = 32'hfd3b;
    rst <= 1'b1;
    port_a <= '0;
    port_b <= '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (4) drive('0, '0);                            // outputs stay zero with no reads
    // full-word sweep hits every bank through interleaving
    for (int i = 0; i < MEM_DEPTH; i++) begin
      rng = xorshift(rng);
      drive(write_req(ADDR_WIDTH'(i), 4'hf, rng), '0);
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
      drive(read_req(ADDR_WIDTH'(i)), b_read_req(ADDR_WIDTH'(MEM_DEPTH - 1 - i)));
    end
    // random byte masks, each followed by a read-back
    for (int n = 0; n < 100; n++) begin
      rng = xorshift(rng);
      addr = rng[10:0];
      ctl = rng;
      rng = xorshift(rng);
      drive(write_req(addr, ctl[14:11], rng), '0);
      drive(read_req(addr), '0);
    end
    // same-address collisions, port B must see the old word first
    for (int n = 0; n < 100; n++) begin
      rng = xorshift(rng);
      addr = rng[10:0];
      rng = xorshift(rng);
      drive(write_req(addr, 4'hf, rng), b_read_req(addr));
      drive(read_req(addr ^ 11'h1), b_read_req(addr));
    end
    // hold through writes and idle cycles
    for (int n = 0; n < 10; n++) begin
      rng = xorshift(rng);
      addr = rng[10:0];
      drive(read_req(addr), b_read_req(~addr));
      rng = xorshift(rng);
      drive(write_req(addr, 4'hf, rng), '0);
      repeat (3) drive('0, '0);
    end
    // random mixed traffic on both ports
    for (int n = 0; n < 2000; n++) begin
      rng = xorshift(rng);
      ctl = rng;
      rng = xorshift(rng);
      a_req = write_req(ctl[12:2], ctl[16:13], rng);
      a_req.en = ctl[0] | ctl[29];
      a_req.we = ctl[1];
      b_req = b_read_req(ctl[27:17]);
      b_req.en = ctl[28];
      drive(a_req, b_req);
    end
    repeat (4) drive('0, '0);                            // let the last reads return
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- hw/bank_router.sv
`timescale 1ns/1ns

module bank_router (
  input  mem_port_pkg::rw_req_t   port_a,
  input  mem_port_pkg::rd_req_t   port_b,
  output mem_port_pkg::bank_rw_t  bank_rw [mem_cfg_pkg::NUM_BANKS],
  output mem_port_pkg::bank_rd_t  bank_rd [mem_cfg_pkg::NUM_BANKS]
);

  import mem_cfg_pkg::*;
  import mem_port_pkg::*;

  logic [NUM_BANKS-1:0] sel_a;                           // one-hot bank select, port A
  logic [NUM_BANKS-1:0] sel_b;                           // one-hot bank select, port B

  // decode bank field of each address
  always_comb begin
    sel_a = '0;
    sel_b = '0;
    sel_a[port_a.addr.fields.bank] = port_a.en;
    sel_b[port_b.addr.fields.bank] = port_b.en;
  end

  // port A fan-out, unselected banks see an idle request
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_rw[b] = '0;
      if (sel_a[b]) begin
        bank_rw[b].en    = 1'b1;
        bank_rw[b].we    = port_a.we;
        bank_rw[b].wmask = port_a.wmask;
        bank_rw[b].row   = port_a.addr.fields.row;
        bank_rw[b].wdata = port_a.wdata;
      end
    end
  end

  // port B fan-out
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_rd[b] = '0;
      if (sel_b[b]) begin
        bank_rd[b].en  = 1'b1;
        bank_rd[b].row = port_b.addr.fields.row;
      end
    end
  end

endmodule

//--- hw/banked_sram_top.sv
`timescale 1ns/1ns

module banked_sram_top (
  input  logic                                clk,
  input  logic                                rst,
  input  mem_port_pkg::rw_req_t               port_a,
  input  mem_port_pkg::rd_req_t               port_b,
  output logic [mem_cfg_pkg::DATA_WIDTH-1:0]  rdata_a,
  output logic [mem_cfg_pkg::DATA_WIDTH-1:0]  rdata_b
);

  import mem_cfg_pkg::*;
  import mem_port_pkg::*;

  bank_rw_t              bank_rw  [NUM_BANKS];           // decoded per-bank requests
  bank_rd_t              bank_rd  [NUM_BANKS];
  logic [DATA_WIDTH-1:0] rw_rdata [NUM_BANKS];           // bank words for port A
  logic [DATA_WIDTH-1:0] rd_rdata [NUM_BANKS];           // bank words for port B

  bank_router u_router (
    .port_a  (port_a),
    .port_b  (port_b),
    .bank_rw (bank_rw),
    .bank_rd (bank_rd)
  );

  // interleaved banks
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    sram_bank u_bank (
      .clk      (clk),
      .rw       (bank_rw[b]),
      .rd       (bank_rd[b]),
      .rw_rdata (rw_rdata[b]),
      .rd_rdata (rd_rdata[b])
    );
  end

  // port A returns only on reads, writes leave rdata_a alone
  read_return_mux u_ret_a (
    .clk        (clk),
    .rst        (rst),
    .rd_en      (port_a.en && !port_a.we),
    .bank_sel   (port_a.addr.fields.bank),
    .bank_rdata (rw_rdata),
    .rdata      (rdata_a)
  );

  read_return_mux u_ret_b (
    .clk        (clk),
    .rst        (rst),
    .rd_en      (port_b.en),
    .bank_sel   (port_b.addr.fields.bank),
    .bank_rdata (rd_rdata),
    .rdata      (rdata_b)
  );

endmodule

//--- hw/mem_cfg_pkg.sv
package mem_cfg_pkg;

  // word geometry
  localparam int DATA_WIDTH = 32;
  localparam int NUM_WMASKS = 4;                         // one mask bit per byte
  localparam int LANE_WIDTH = DATA_WIDTH / NUM_WMASKS;   // bits per mask lane

  // memory and bank geometry
  localparam int MEM_DEPTH  = 2048;                      // words in the whole memory
  localparam int NUM_BANKS  = 8;
  localparam int BANK_DEPTH = MEM_DEPTH / NUM_BANKS;     // words per bank

  // address split, low bits interleave across banks
  localparam int ADDR_WIDTH = $clog2(MEM_DEPTH);
  localparam int BANK_BITS  = $clog2(NUM_BANKS);
  localparam int ROW_BITS   = $clog2(BANK_DEPTH);

  typedef struct packed {
    logic [ROW_BITS-1:0]  row;                           // upper bits, row in bank
    logic [BANK_BITS-1:0] bank;                          // lower bits, bank index
  } addr_fields_t;

  // the same word address, seen flat or as bank/row
  typedef union packed {
    logic [ADDR_WIDTH-1:0] flat;
    addr_fields_t          fields;
  } mem_addr_u;

endpackage

//--- hw/mem_port_pkg.sv
package mem_port_pkg;

  import mem_cfg_pkg::*;

  // port A request, read when we is low, write when high
  typedef struct packed {
    logic                  en;                           // request valid this cycle
    logic                  we;                           // write enable
    logic [NUM_WMASKS-1:0] wmask;                        // byte lanes to write
    mem_addr_u             addr;
    logic [DATA_WIDTH-1:0] wdata;
  } rw_req_t;

  // port B request, read only
  typedef struct packed {
    logic      en;
    mem_addr_u addr;
  } rd_req_t;

  // per-bank read-write request, after address decode
  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [NUM_WMASKS-1:0] wmask;
    logic [ROW_BITS-1:0]   row;                          // row inside the bank
    logic [DATA_WIDTH-1:0] wdata;
  } bank_rw_t;

  // per-bank read request
  typedef struct packed {
    logic                en;
    logic [ROW_BITS-1:0] row;
  } bank_rd_t;

endpackage

//--- hw/read_return_mux.sv
`timescale 1ns/1ns

module read_return_mux (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 rd_en,        // read issued this cycle
  input  logic [mem_cfg_pkg::BANK_BITS-1:0]    bank_sel,
  input  logic [mem_cfg_pkg::DATA_WIDTH-1:0]   bank_rdata [mem_cfg_pkg::NUM_BANKS],
  output logic [mem_cfg_pkg::DATA_WIDTH-1:0]   rdata
);

  import mem_cfg_pkg::*;

  logic                 pend_valid;                      // bank data lands next edge
  logic [BANK_BITS-1:0] pend_bank;                       // bank that read went to

  // first edge: remember the outstanding read
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_valid <= 1'b0;
    end else begin
      pend_valid <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      pend_bank <= bank_sel;
    end
  end

  // second edge: capture the bank word, otherwise hold
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else if (pend_valid) begin
      rdata <= bank_rdata[pend_bank];
    end
  end

endmodule

//--- hw/sram_bank.sv
`timescale 1ns/1ns

module sram_bank (
  input  logic                                clk,
  input  mem_port_pkg::bank_rw_t              rw,
  input  mem_port_pkg::bank_rd_t              rd,
  output logic [mem_cfg_pkg::DATA_WIDTH-1:0]  rw_rdata,
  output logic [mem_cfg_pkg::DATA_WIDTH-1:0]  rd_rdata
);

  import mem_cfg_pkg::*;

  logic [DATA_WIDTH-1:0] mem [BANK_DEPTH];

  // banks come up cleared
  initial begin
    for (int i = 0; i < BANK_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // masked write on the read-write port
  always_ff @(posedge clk) begin
    if (rw.en && rw.we) begin
      for (int lane = 0; lane < NUM_WMASKS; lane++) begin
        if (rw.wmask[lane]) begin
          mem[rw.row][lane*LANE_WIDTH +: LANE_WIDTH] <=
            rw.wdata[lane*LANE_WIDTH +: LANE_WIDTH];
        end
      end
    end
  end

  // read on the read-write port, held on writes and idle cycles
  always_ff @(posedge clk) begin
    if (rw.en && !rw.we) begin
      rw_rdata <= mem[rw.row];
    end
  end

  // read-only port sees the word from before this edge's write
  always_ff @(posedge clk) begin
    if (rd.en) begin
      rd_rdata <= mem[rd.row];
    end
  end

endmodule

//--- tb.f
hw/mem_cfg_pkg.sv
hw/mem_port_pkg.sv
hw/sram_bank.sv
hw/bank_router.sv
hw/read_return_mux.sv
hw/banked_sram_top.sv
bench/banked_sram_asserts.sv
bench/tb_banked_sram.sv
